// File: fetch_config.svh
// Sizes must stay powers of two and one cache line must hold exactly FETCH_LANES words
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// ------------------------------
// Address and lane geometry
// ------------------------------
`define FETCH_ADDR_W 32
// Instructions per fetched line, one 64-bit doubleword
`define FETCH_LANES 2

// ------------------------------
// Storage sizes
// ------------------------------
`define ICACHE_LINES 16
`define BTB_ENTRIES 8

// PC loaded while reset is high
`define FETCH_RESET_PC 32'h0000_0000
// addi x0, x0, 0 placed in lanes that carry no instruction
`define FETCH_NOP 32'h0000_0013

`endif

// File: fetch_pkg.sv
// Shared fetch types sized from fetch_config.svh and only valid for a one-doubleword line
`include "fetch_config.svh"

package fetch_pkg;

    // Lane index width and byte offset bits inside one line
    localparam int unsigned LANE_W     = $clog2(`FETCH_LANES);
    localparam int unsigned LINE_OFF_W = LANE_W + 2;

    // Cache line seen as a whole doubleword or as per-lane words
    typedef union packed {
        logic [63:0]                  dword;
        logic [`FETCH_LANES-1:0][31:0] word;
    } mem_line_u;

    // One instruction slot handed to dispatch
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [`FETCH_ADDR_W-1:0] npc;
        logic [31:0]              inst;
    } if_packet_t;

    // Full fetch packet, lane 0 in the low slot
    typedef if_packet_t [`FETCH_LANES-1:0] fetch_bundle_t;

    // Mispredict or flush from execute
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] target;
    } redirect_t;

    // Resolved branch outcome used for training
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] pc;
        logic                     taken;
        logic [`FETCH_ADDR_W-1:0] target;
    } resolve_t;

    // One prediction per line, lane names the branch slot
    typedef struct packed {
        logic                     valid;
        logic                     taken;
        logic [LANE_W-1:0]        lane;
        logic [`FETCH_ADDR_W-1:0] target;
    } prediction_t;

    // Refill port toward memory
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] addr;
    } refill_req_t;

    typedef struct packed {
        logic      valid;
        mem_line_u line;
    } refill_rsp_t;

endpackage

// File: stage_if.sv
// Bundle is combinational from the PC and needs the cache hit in the same cycle to be valid
`timescale 1ns/100ps
`include "fetch_config.svh"

module stage_if (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     ready_i,
    input  fetch_pkg::redirect_t     redirect_i,
    input  logic                     hit_i,
    input  fetch_pkg::mem_line_u     line_i,
    input  fetch_pkg::prediction_t   pred_i,
    output logic [`FETCH_ADDR_W-1:0] fetch_addr_o,
    output fetch_pkg::fetch_bundle_t bundle_o
);
    import fetch_pkg::*;

    logic [`FETCH_ADDR_W-1:0] pc_q;
    logic [`FETCH_ADDR_W-1:0] pc_d;
    logic [`FETCH_ADDR_W-1:0] line_base;
    logic [LANE_W-1:0]        first_lane;
    logic                     advance;
    logic                     pred_taken;

    // ------------------------------
    // Line address and entry lane
    // ------------------------------
    // Cache and predictor both see the aligned line
    assign line_base    = {pc_q[`FETCH_ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    assign fetch_addr_o = line_base;

    // Word offset of the PC, nonzero after a jump into the middle of a line
    assign first_lane = pc_q[2 +: LANE_W];

    // Dispatch takes the bundle only on a hit with ready high
    assign advance = hit_i && ready_i && !redirect_i.valid;

    // Prediction counts only if its branch lane was actually fetched
    assign pred_taken = pred_i.valid && pred_i.taken && (pred_i.lane >= first_lane);

    // ------------------------------
    // Next-PC priority
    // ------------------------------
    always_comb begin
        // Hold by default, covers miss and back-pressure
        pc_d = pc_q;
        if (redirect_i.valid) begin
            // Execute correction wins over everything
            pc_d = redirect_i.target;
        end else if (advance && pred_taken) begin
            pc_d = pred_i.target;
        end else if (advance) begin
            // Sequential step always lands on the next aligned line
            pc_d = line_base + `FETCH_ADDR_W'(`FETCH_LANES * 4);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // ------------------------------
    // Lane packing
    // ------------------------------
    for (genvar k = 0; k < `FETCH_LANES; k++) begin : g_lane
        logic [`FETCH_ADDR_W-1:0] lane_pc;
        logic                     lane_valid;

        // Slot address is fixed by its position in the line
        assign lane_pc = line_base + `FETCH_ADDR_W'(4 * k);

        always_comb begin
            // Nothing is valid without a hit or while a redirect is applied
            lane_valid = hit_i && !redirect_i.valid;
            // Slots before the entry point were skipped over
            if (LANE_W'(k) < first_lane) begin
                lane_valid = 1'b0;
            end
            // Slots after a taken branch are on the wrong path
            if (pred_taken && (LANE_W'(k) > pred_i.lane)) begin
                lane_valid = 1'b0;
            end
        end

        assign bundle_o[k].valid = lane_valid;
        assign bundle_o[k].pc    = lane_pc;
        assign bundle_o[k].npc   = lane_pc + `FETCH_ADDR_W'(4);
        // Word view picks this slot out of the line
        assign bundle_o[k].inst  = lane_valid ? line_i.word[k] : `FETCH_NOP;
    end

endmodule

// File: icache.sv
// Direct mapped with no invalidation and a single outstanding refill
`timescale 1ns/100ps
`include "fetch_config.svh"

module icache (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [`FETCH_ADDR_W-1:0] addr_i,
    output logic                     hit_o,
    output fetch_pkg::mem_line_u     line_o,
    output fetch_pkg::refill_req_t   refill_req_o,
    input  fetch_pkg::refill_rsp_t   refill_rsp_i
);
    import fetch_pkg::*;

    localparam int unsigned IDX_W = $clog2(`ICACHE_LINES);
    localparam int unsigned TAG_W = `FETCH_ADDR_W - IDX_W - LINE_OFF_W;

    // ------------------------------
    // Storage
    // ------------------------------
    logic [`ICACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]         tag_q [`ICACHE_LINES];
    mem_line_u                data_q [`ICACHE_LINES];

    // Refill tracking
    logic                     pending_q;
    logic [`FETCH_ADDR_W-1:0] pend_addr_q;

    logic [IDX_W-1:0]         rd_idx;
    logic [TAG_W-1:0]         rd_tag;
    logic [IDX_W-1:0]         wr_idx;
    logic [TAG_W-1:0]         wr_tag;
    logic                     lookup_hit;
    logic [`FETCH_ADDR_W-1:0] miss_addr;

    // ------------------------------
    // Lookup
    // ------------------------------
    assign rd_idx = addr_i[LINE_OFF_W +: IDX_W];
    assign rd_tag = addr_i[`FETCH_ADDR_W-1 -: TAG_W];

    assign lookup_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // No hit is reported until the outstanding refill has landed
    assign hit_o  = lookup_hit && !pending_q;
    assign line_o = data_q[rd_idx];

    // ------------------------------
    // Refill request
    // ------------------------------
    assign miss_addr = {addr_i[`FETCH_ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

    // Raised combinationally on a miss, then held from the latched address
    assign refill_req_o.valid = pending_q || !lookup_hit;
    assign refill_req_o.addr  = pending_q ? pend_addr_q : miss_addr;

    // Returning line goes where the request pointed
    assign wr_idx = refill_req_o.addr[LINE_OFF_W +: IDX_W];
    assign wr_tag = refill_req_o.addr[`FETCH_ADDR_W-1 -: TAG_W];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q   <= '0;
            pending_q <= 1'b0;
        end else begin
            if (refill_rsp_i.valid) begin
                // Line becomes usable on the following cycle
                valid_q[wr_idx] <= 1'b1;
                pending_q       <= 1'b0;
            end else if (refill_req_o.valid) begin
                pending_q <= 1'b1;
            end
        end
    end

    // Address latch follows the lookup until a request is in flight
    always_ff @(posedge clock) begin
        if (!pending_q) begin
            pend_addr_q <= miss_addr;
        end
    end

    // Tag and data write on the response edge
    always_ff @(posedge clock) begin
        if (refill_rsp_i.valid) begin
            tag_q[wr_idx]        <= wr_tag;
            data_q[wr_idx].dword <= refill_rsp_i.line.dword;
        end
    end

endmodule

// File: branch_predictor.sv
// One branch per line is tracked and a resolve overwrites any entry that aliases its index
`timescale 1ns/100ps
`include "fetch_config.svh"

module branch_predictor (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [`FETCH_ADDR_W-1:0] addr_i,
    output fetch_pkg::prediction_t   pred_o,
    input  fetch_pkg::resolve_t      resolve_i
);
    import fetch_pkg::*;

    localparam int unsigned IDX_W = $clog2(`BTB_ENTRIES);
    localparam int unsigned TAG_W = `FETCH_ADDR_W - IDX_W - LINE_OFF_W;

    // ------------------------------
    // BTB arrays
    // ------------------------------
    logic [`BTB_ENTRIES-1:0]  valid_q;
    logic [TAG_W-1:0]         tag_q    [`BTB_ENTRIES];
    logic [LANE_W-1:0]        lane_q   [`BTB_ENTRIES];
    logic [`FETCH_ADDR_W-1:0] target_q [`BTB_ENTRIES];
    // Two-bit counter, upper bit is the taken guess
    logic [1:0]               ctr_q    [`BTB_ENTRIES];

    logic [IDX_W-1:0]         rd_idx;
    logic [TAG_W-1:0]         rd_tag;
    logic                     rd_match;
    logic [IDX_W-1:0]         wr_idx;
    logic [TAG_W-1:0]         wr_tag;
    logic [LANE_W-1:0]        wr_lane;
    logic                     wr_exists;
    logic [1:0]               ctr_d;
    logic [`FETCH_ADDR_W-1:0] target_d;

    // ------------------------------
    // Lookup per fetched line
    // ------------------------------
    assign rd_idx   = addr_i[LINE_OFF_W +: IDX_W];
    assign rd_tag   = addr_i[`FETCH_ADDR_W-1 -: TAG_W];
    assign rd_match = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    assign pred_o.valid  = rd_match;
    assign pred_o.taken  = rd_match && ctr_q[rd_idx][1];
    assign pred_o.lane   = lane_q[rd_idx];
    assign pred_o.target = target_q[rd_idx];

    // ------------------------------
    // Training from execute
    // ------------------------------
    assign wr_idx  = resolve_i.pc[LINE_OFF_W +: IDX_W];
    assign wr_tag  = resolve_i.pc[`FETCH_ADDR_W-1 -: TAG_W];
    assign wr_lane = resolve_i.pc[2 +: LANE_W];

    // Same line and same slot counts as the entry being trained
    assign wr_exists = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag)
                       && (lane_q[wr_idx] == wr_lane);

    always_comb begin
        // Fresh entry starts weakly biased toward the outcome
        ctr_d    = resolve_i.taken ? 2'd2 : 2'd1;
        target_d = resolve_i.target;
        if (wr_exists) begin
            if (resolve_i.taken) begin
                ctr_d = (ctr_q[wr_idx] == 2'd3) ? 2'd3 : ctr_q[wr_idx] + 2'd1;
            end else begin
                ctr_d = (ctr_q[wr_idx] == 2'd0) ? 2'd0 : ctr_q[wr_idx] - 2'd1;
                // Not-taken outcome carries no useful target
                target_d = target_q[wr_idx];
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else if (resolve_i.valid) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (resolve_i.valid) begin
            tag_q[wr_idx]    <= wr_tag;
            lane_q[wr_idx]   <= wr_lane;
            target_q[wr_idx] <= target_d;
            ctr_q[wr_idx]    <= ctr_d;
        end
    end

endmodule

// File: fetch_top.sv
// Fetch front end whose refill port expects a one-cycle response pulse after any latency
`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_top (
    input  logic                     clock,
    input  logic                     reset,
    // Dispatch side
    input  logic                     ready_i,
    output fetch_pkg::fetch_bundle_t bundle_o,
    // Execute side
    input  fetch_pkg::redirect_t     redirect_i,
    input  fetch_pkg::resolve_t      resolve_i,
    // Memory refill port
    output fetch_pkg::refill_req_t   refill_req_o,
    input  fetch_pkg::refill_rsp_t   refill_rsp_i
);
    import fetch_pkg::*;

    // ------------------------------
    // Internal nets
    // ------------------------------
    // Aligned line address shared by cache and predictor
    logic [`FETCH_ADDR_W-1:0] fetch_addr;
    logic                     hit;
    mem_line_u                line;
    prediction_t              pred;

    // PC owner and bundle packing
    stage_if u_stage_if (
        .clock        (clock),
        .reset        (reset),
        .ready_i      (ready_i),
        .redirect_i   (redirect_i),
        .hit_i        (hit),
        .line_i       (line),
        .pred_i       (pred),
        .fetch_addr_o (fetch_addr),
        .bundle_o     (bundle_o)
    );

    // One line per cycle with external refill
    icache u_icache (
        .clock        (clock),
        .reset        (reset),
        .addr_i       (fetch_addr),
        .hit_o        (hit),
        .line_o       (line),
        .refill_req_o (refill_req_o),
        .refill_rsp_i (refill_rsp_i)
    );

    // Looked up with the same line address
    branch_predictor u_branch_predictor (
        .clock     (clock),
        .reset     (reset),
        .addr_i    (fetch_addr),
        .pred_o    (pred),
        .resolve_i (resolve_i)
    );

endmodule

// File: fetch_tb_clock.sv
// Free-running 20 ns clock with reset released 2 ns after the fourth rising edge
`timescale 1ns/100ps

module fetch_tb_clock (
    output logic clock_o,
    output logic reset_o
);

    initial begin
        clock_o = 1'b0;
        forever #10 clock_o = ~clock_o;
    end

    // Reset drops at the same drive point as the stimulus
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge clock_o);
        #2;
        reset_o = 1'b0;
    end

endmodule

// File: fetch_props.sv
// Checks assume two lanes per line and follow only the most recently resolved branch
`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_props (
    input logic                     clock,
    input logic                     reset,
    input logic                     ready_i,
    input fetch_pkg::fetch_bundle_t bundle_i,
    input fetch_pkg::redirect_t     redirect_i,
    input fetch_pkg::resolve_t      resolve_i,
    input fetch_pkg::refill_req_t   refill_req_i,
    input fetch_pkg::refill_rsp_t   refill_rsp_i
);
    import fetch_pkg::*;

    localparam int unsigned IDX_W = $clog2(`ICACHE_LINES);

    int unsigned fail_count = 0;

    logic        any_valid;
    logic [31:0] first_pc;
    logic        br_taken;
    logic [IDX_W-1:0] req_idx;
    logic [31:0] req_tag;
    logic        req_cached;
    // Branch model state
    logic        br_valid_q;
    logic [31:0] br_pc_q;
    logic [1:0]  br_ctr_q;
    logic [31:0] br_target_q;
    // Address the next accepted bundle must start at
    logic [31:0] start_pc_q;
    // Lines already delivered by memory, same indexing as the cache
    logic [`ICACHE_LINES-1:0] seen_q;
    logic [31:0] seen_tag_q [`ICACHE_LINES];

    // Same word rule as the memory model
    function automatic logic [31:0] memory_word(logic [31:0] addr);
        return {addr[26:2] ^ {20'd0, addr[31:27]}, 7'h13} ^ 32'h5AC3_0000;
    endfunction

    // ------------------------------
    // Reference state
    // ------------------------------
    assign any_valid = bundle_i[0].valid || bundle_i[1].valid;
    assign first_pc  = bundle_i[0].valid ? bundle_i[0].pc : bundle_i[1].pc;
    // Taken only if the branch slot was fetched from this entry point
    assign br_taken  = br_valid_q && br_ctr_q[1] && (br_pc_q[31:3] == bundle_i[0].pc[31:3])
                       && (br_pc_q[2] >= !bundle_i[0].valid);
    assign req_idx    = refill_req_i.addr[3 +: IDX_W];
    assign req_tag    = refill_req_i.addr >> (3 + IDX_W);
    assign req_cached = seen_q[req_idx] && (seen_tag_q[req_idx] == req_tag);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            br_valid_q  <= 1'b0;
            br_pc_q     <= '0;
            br_ctr_q    <= '0;
            br_target_q <= '0;
            start_pc_q  <= `FETCH_RESET_PC;
            seen_q      <= '0;
        end else begin
            if (resolve_i.valid) begin
                br_valid_q <= 1'b1;
                br_pc_q    <= resolve_i.pc;
                if (br_valid_q && (br_pc_q == resolve_i.pc)) begin
                    // Saturating step toward the outcome
                    if (resolve_i.taken && (br_ctr_q != 2'd3)) begin
                        br_ctr_q <= br_ctr_q + 2'd1;
                    end else if (!resolve_i.taken && (br_ctr_q != 2'd0)) begin
                        br_ctr_q <= br_ctr_q - 2'd1;
                    end
                    if (resolve_i.taken) begin
                        br_target_q <= resolve_i.target;
                    end
                end else begin
                    br_ctr_q    <= resolve_i.taken ? 2'd2 : 2'd1;
                    br_target_q <= resolve_i.target;
                end
            end
            if (redirect_i.valid) begin
                start_pc_q <= redirect_i.target;
            end else if (any_valid && ready_i) begin
                start_pc_q <= br_taken ? br_target_q : bundle_i[0].pc + 32'd8;
            end
            if (refill_rsp_i.valid) begin
                seen_q[req_idx]     <= 1'b1;
                seen_tag_q[req_idx] <= req_tag;
            end
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    for (genvar k = 0; k < 2; k++) begin : g_lane
        a_lane: assert property (@(posedge clock) disable iff (reset)
            bundle_i[k].valid |-> (bundle_i[k].pc[2:0] == 3'(4 * k))
                && (bundle_i[k].npc == bundle_i[k].pc + 32'd4)
                && (bundle_i[k].inst == memory_word(bundle_i[k].pc)))
        else begin
            fail_count++;
            $error("bundle_o[%0d] pc %h npc %h inst %h, expected inst %h", k,
                   $sampled(bundle_i[k].pc), $sampled(bundle_i[k].npc),
                   $sampled(bundle_i[k].inst), memory_word($sampled(bundle_i[k].pc)));
        end
    end

    a_quiet: assert property (@(posedge clock) disable iff (reset)
        (refill_req_i.valid || redirect_i.valid) |-> !any_valid)
    else begin
        fail_count++;
        $error("A lane was valid during a refill or a redirect");
    end

    a_req_hold: assert property (@(posedge clock) disable iff (reset)
        (refill_req_i.valid && !refill_rsp_i.valid)
            |=> refill_req_i.valid && $stable(refill_req_i.addr))
    else begin
        fail_count++;
        $error("Refill request dropped or moved before its response");
    end

    a_no_refetch: assert property (@(posedge clock) disable iff (reset)
        refill_req_i.valid |-> !req_cached)
    else begin
        fail_count++;
        $error("Refill requested again for cached line %h", $sampled(refill_req_i.addr));
    end

    a_start: assert property (@(posedge clock) disable iff (reset)
        any_valid |-> (first_pc == start_pc_q))
    else begin
        fail_count++;
        $error("bundle_o start pc %h, expected %h", $sampled(first_pc), $sampled(start_pc_q));
    end

    a_pred_lane: assert property (@(posedge clock) disable iff (reset)
        any_valid |-> (bundle_i[1].valid == !(br_taken && !br_pc_q[2])))
    else begin
        fail_count++;
        $error("bundle_o[1].valid %h, expected %h", $sampled(bundle_i[1].valid),
               $sampled(!(br_taken && !br_pc_q[2])));
    end

    a_stall: assert property (@(posedge clock) disable iff (reset)
        (any_valid && !ready_i) |=> redirect_i.valid || $stable(bundle_i))
    else begin
        fail_count++;
        $error("Bundle changed while ready was low");
    end

endmodule

bind fetch_top fetch_props u_props (
    .clock        (clock),
    .reset        (reset),
    .ready_i      (ready_i),
    .bundle_i     (bundle_o),
    .redirect_i   (redirect_i),
    .resolve_i    (resolve_i),
    .refill_req_i (refill_req_o),
    .refill_rsp_i (refill_rsp_i)
);

// File: fetch_tb.sv
// Memory answers each refill after 1 to 4 cycles and all checking sits in the bound fetch_props
`timescale 1ns/100ps
`include "fetch_config.svh"

module fetch_tb;
    import fetch_pkg::*;

    // Tests need a few hundred cycles
    localparam int unsigned CYCLE_LIMIT = 2000;

    logic          clock;
    logic          reset;
    logic          ready;
    redirect_t     redirect;
    resolve_t      resolve;
    refill_req_t   refill_req;
    refill_rsp_t   refill_rsp;
    fetch_bundle_t bundle;

    logic [15:0] lfsr_q;
    int unsigned tests_run;
    int unsigned tests_failed;
    int unsigned fails_seen;

    fetch_tb_clock u_clock (
        .clock_o (clock),
        .reset_o (reset)
    );

    fetch_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .ready_i      (ready),
        .bundle_o     (bundle),
        .redirect_i   (redirect),
        .resolve_i    (resolve),
        .refill_req_o (refill_req),
        .refill_rsp_i (refill_rsp)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_next_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    // Opcode stays OP-IMM so no word decodes as a branch
    function automatic logic [31:0] memory_word(logic [31:0] addr);
        return {addr[26:2] ^ {20'd0, addr[31:27]}, 7'h13} ^ 32'h5AC3_0000;
    endfunction

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic send_redirect(input logic [31:0] target);
        redirect.valid  = 1'b1;
        redirect.target = target;
        next_cycle();
        redirect = '0;
    endtask

    task automatic send_resolve(input logic [31:0] pc, input logic taken,
                                input logic [31:0] target);
        resolve.valid  = 1'b1;
        resolve.pc     = pc;
        resolve.taken  = taken;
        resolve.target = target;
        next_cycle();
        resolve = '0;
    endtask

    // Waits until dispatch has taken the given number of bundles
    task automatic fetch_bundles(input int unsigned count);
        int unsigned accepted;
        accepted = 0;
        while (accepted < count) begin
            @(negedge clock);
            if (ready && (bundle[0].valid || bundle[1].valid)) begin
                accepted++;
            end
        end
        next_cycle();
    endtask

    task automatic finish_test(input string name);
        int unsigned now;
        now = u_dut.u_props.fail_count;
        tests_run++;
        if (now != fails_seen) begin
            tests_failed++;
            $display("Test %s: %0d assertion errors", name, now - fails_seen);
        end else begin
            $display("Test %s: done, no assertion errors", name);
        end
        fails_seen = now;
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------
    initial begin : memory_model
        logic [31:0] addr;
        int unsigned delay;
        lfsr_q     = 16'd5654;
        refill_rsp = '0;
        forever begin
            @(negedge clock);
            if (!reset && refill_req.valid) begin
                addr  = refill_req.addr;
                delay = 1;
                // Two LFSR bits give the extra latency
                for (int b = 0; b < 2; b++) begin
                    delay = delay + (int'(lfsr_next_bit()) << b);
                end
                repeat (delay) @(posedge clock);
                #2;
                refill_rsp.valid      = 1'b1;
                refill_rsp.line.dword = {memory_word(addr + 32'd4), memory_word(addr)};
                @(posedge clock);
                #2;
                refill_rsp = '0;
            end
        end
    end

    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout after %0d cycles with tests still running", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : test_sequence
        ready        = 1'b1;
        redirect     = '0;
        resolve      = '0;
        tests_run    = 0;
        tests_failed = 0;
        fails_seen   = 0;
        wait (reset == 1'b0);

        fetch_bundles(8);
        finish_test("sequential");

        // Second pass over the loop must hit
        send_redirect(32'h0000_0100);
        fetch_bundles(4);
        send_redirect(32'h0000_0100);
        fetch_bundles(4);
        finish_test("miss_then_hit");

        // Aligned target, then a misaligned one while a refill is pending
        send_redirect(32'h0000_0200);
        fetch_bundles(2);
        send_redirect(32'h0000_0300);
        next_cycle();
        send_redirect(32'h0000_020C);
        fetch_bundles(2);
        finish_test("redirect");

        ready = 1'b0;
        send_redirect(32'h0000_0400);
        repeat (8) next_cycle();
        ready = 1'b1;
        fetch_bundles(2);
        finish_test("back_pressure");

        // Lane 0 branch trained taken, then back to not taken
        send_resolve(32'h0000_0500, 1'b1, 32'h0000_0600);
        send_resolve(32'h0000_0500, 1'b1, 32'h0000_0600);
        send_redirect(32'h0000_04F0);
        fetch_bundles(4);
        send_resolve(32'h0000_0500, 1'b0, 32'h0000_0600);
        send_resolve(32'h0000_0500, 1'b0, 32'h0000_0600);
        send_redirect(32'h0000_04F8);
        fetch_bundles(3);
        // Lane 1 branch into the middle of a line
        send_resolve(32'h0000_0704, 1'b1, 32'h0000_07A4);
        send_resolve(32'h0000_0704, 1'b1, 32'h0000_07A4);
        send_redirect(32'h0000_0700);
        fetch_bundles(3);
        finish_test("prediction");

        $display("Summary: %0d tests run, %0d failed, %0d assertion errors",
                 tests_run, tests_failed, fails_seen);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
fetch_pkg.sv
stage_if.sv
icache.sv
branch_predictor.sv
fetch_top.sv
fetch_tb_clock.sv
fetch_props.sv
fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - stage_if.sv
      - icache.sv
      - branch_predictor.sv
      - fetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fetch_tb_clock.sv
      - fetch_props.sv
      - fetch_tb.sv
